// ==== logic/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

  //////////////////////////////////////////////////////////////////////
  // Architectural sizes
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_REGS = 8;
  localparam int DATA_W   = 16;

  typedef logic [2:0] rf_addr_t;

  // Codes above CSRR decode as illegal
  typedef enum logic [3:0] {
    NOP  = 4'd0,
    ADD  = 4'd1,
    SUB  = 4'd2,
    AND  = 4'd3,
    OR   = 4'd4,
    XOR  = 4'd5,
    ADDI = 4'd6,
    LD   = 4'd7,
    ST   = 4'd8,
    CSRW = 4'd9,
    CSRR = 4'd10
  } op_e;

  //////////////////////////////////////////////////////////////////////
  // Instruction format
  //////////////////////////////////////////////////////////////////////

  // Register form of the low six bits
  typedef struct packed {
    rf_addr_t   rs2;
    logic [2:0] spare;
  } instr_rr_t;

  // Low six bits read either as rs2 or as immediate
  typedef union packed {
    instr_rr_t  rr;
    logic [5:0] imm;
  } instr_lo_u;

  typedef struct packed {
    logic [3:0] op;
    rf_addr_t   rd;
    rf_addr_t   rs1;
    instr_lo_u  lo;
  } instr_t;

  //////////////////////////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic              instr_valid;
    op_e               op;
    logic              rf_we;
    rf_addr_t          rf_waddr;
    logic              lsu_en;
    logic              lsu_we;
    logic              csr_we;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
    logic [DATA_W-1:0] st_data;
    // Sign-extended immediate
    logic [DATA_W-1:0] imm;
  } id_ex_pipe_t;

  typedef struct packed {
    logic              instr_valid;
    logic              rf_we;
    rf_addr_t          rf_waddr;
    logic              lsu_en;
    logic              lsu_we;
    logic              csr_we;
    // ALU result or memory address
    logic [DATA_W-1:0] result;
    logic [DATA_W-1:0] st_data;
  } ex_wb_pipe_t;

  // One entry per retired instruction
  typedef struct packed {
    logic              valid;
    logic              we;
    rf_addr_t          waddr;
    logic [DATA_W-1:0] wdata;
  } retire_t;

endpackage

`default_nettype wire

// ==== logic/byp_pkg.sv ====
`default_nettype none

package byp_pkg;

  // Operand source for each register file read port
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Bypass and hazard controls toward ID
  typedef struct packed {
    fw_sel_e operand_a_fw_mux_sel;
    fw_sel_e operand_b_fw_mux_sel;
    // Hold ID and bubble EX
    logic    load_stall;
    logic    csr_stall;
    // Clear write enables of the ID instruction
    logic    deassert_we;
  } ctrl_byp_t;

endpackage

`default_nettype wire

// ==== logic/pipe_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_regfile
  import pipe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  rf_addr_t          raddr_i [2],
  output logic [DATA_W-1:0] rdata_o [2],
  input  logic              we_i,
  input  rf_addr_t          waddr_i,
  input  logic [DATA_W-1:0] wdata_i
);

  logic [DATA_W-1:0] regs_q [NUM_REGS];

  // Write port, r0 never stored
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  for (genvar i = 0; i < 2; i++) begin : gen_read
    assign rdata_o[i] = (raddr_i[i] == '0) ? '0 : regs_q[raddr_i[i]];
  end

  // Decoder drops rd == 0 so WB never targets r0
  a_no_r0_write : assert property (@(posedge clk) disable iff (!rst_n_i)
    we_i |-> (waddr_i != '0));

endmodule

`default_nettype wire

// ==== logic/pipe_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_id_stage
  import pipe_pkg::*;
  import byp_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              instr_valid_i,
  input  instr_t            instr_i,
  output logic              instr_ready_o,
  output logic [1:0]        rf_re_o,
  output rf_addr_t          rf_raddr_o [2],
  input  logic [DATA_W-1:0] rf_rdata_i [2],
  output logic              csr_read_o,
  output logic              illegal_o,
  input  logic [DATA_W-1:0] csr_rdata_i,
  input  ctrl_byp_t         ctrl_byp_i,
  input  logic [DATA_W-1:0] ex_fw_data_i,
  input  logic [DATA_W-1:0] wb_fw_data_i,
  input  logic              ex_ready_i,
  output id_ex_pipe_t       id_ex_pipe_o
);

  logic              accept;
  logic              illegal;
  logic [1:0]        rf_re;
  logic              rf_we_dec;
  logic              lsu_en_dec;
  logic              lsu_we_dec;
  logic              csr_we_dec;
  logic              csr_re_dec;
  fw_sel_e           fw_sel [2];
  logic [DATA_W-1:0] fw_data [2];
  logic [DATA_W-1:0] imm_sext;
  id_ex_pipe_t       id_ex_d;
  id_ex_pipe_t       id_ex_q;

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    illegal    = 1'b0;
    rf_re      = 2'b00;
    rf_we_dec  = 1'b0;
    lsu_en_dec = 1'b0;
    lsu_we_dec = 1'b0;
    csr_we_dec = 1'b0;
    csr_re_dec = 1'b0;
    case (instr_i.op)
      NOP: begin
      end
      ADD, SUB, AND, OR, XOR: begin
        rf_re     = 2'b11;
        rf_we_dec = 1'b1;
      end
      ADDI: begin
        rf_re     = 2'b01;
        rf_we_dec = 1'b1;
      end
      LD: begin
        rf_re      = 2'b01;
        rf_we_dec  = 1'b1;
        lsu_en_dec = 1'b1;
      end
      // Store data comes in on port 1 via rd
      ST: begin
        rf_re      = 2'b11;
        lsu_en_dec = 1'b1;
        lsu_we_dec = 1'b1;
      end
      CSRW: begin
        rf_re      = 2'b01;
        csr_we_dec = 1'b1;
      end
      CSRR: begin
        rf_we_dec  = 1'b1;
        csr_re_dec = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  assign rf_re_o       = rf_re;
  assign rf_raddr_o[0] = instr_i.rs1;
  assign rf_raddr_o[1] = (instr_i.op == ST) ? instr_i.rd : instr_i.lo.rr.rs2;
  assign csr_read_o    = csr_re_dec;
  assign illegal_o     = illegal;
  assign imm_sext      = {{(DATA_W-6){instr_i.lo.imm[5]}}, instr_i.lo.imm};

  //////////////////////////////////////////////////////////////////////
  // Operand forwarding
  //////////////////////////////////////////////////////////////////////

  assign fw_sel[0] = ctrl_byp_i.operand_a_fw_mux_sel;
  assign fw_sel[1] = ctrl_byp_i.operand_b_fw_mux_sel;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      case (fw_sel[i])
        SEL_FW_EX: fw_data[i] = ex_fw_data_i;
        SEL_FW_WB: fw_data[i] = wb_fw_data_i;
        default:   fw_data[i] = rf_rdata_i[i];
      endcase
    end
  end

  // Any stall keeps the instruction here
  assign instr_ready_o = ex_ready_i && !ctrl_byp_i.load_stall && !ctrl_byp_i.csr_stall;
  assign accept        = instr_valid_i && instr_ready_o;

  // Not accepted means bubble
  always_comb begin
    id_ex_d.instr_valid = accept;
    id_ex_d.op          = illegal ? NOP : op_e'(instr_i.op);
    // Writes to r0 are dropped here
    id_ex_d.rf_we       = rf_we_dec && (instr_i.rd != '0) && !ctrl_byp_i.deassert_we;
    id_ex_d.rf_waddr    = instr_i.rd;
    id_ex_d.lsu_en      = lsu_en_dec && !ctrl_byp_i.deassert_we;
    id_ex_d.lsu_we      = lsu_we_dec;
    id_ex_d.csr_we      = csr_we_dec && !ctrl_byp_i.deassert_we;
    // CSRR carries the scratch value on operand a
    id_ex_d.operand_a   = csr_re_dec ? csr_rdata_i : fw_data[0];
    id_ex_d.operand_b   = fw_data[1];
    id_ex_d.st_data     = fw_data[1];
    id_ex_d.imm         = imm_sext;
  end

  // ID-to-EX register, holds while EX is busy
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_ex_q.instr_valid <= 1'b0;
    end else if (ex_ready_i) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

  a_stall_blocks_ready : assert property (@(posedge clk) disable iff (!rst_n_i)
    (ctrl_byp_i.load_stall || ctrl_byp_i.csr_stall) |-> !instr_ready_o);

endmodule

`default_nettype wire

// ==== logic/pipe_bypass_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_bypass_ctrl
  import pipe_pkg::*;
  import byp_pkg::*;
(
  input  logic [1:0]  rf_re_id_i,
  input  rf_addr_t    rf_raddr_id_i [2],
  input  logic        csr_read_id_i,
  input  logic        instr_valid_id_i,
  input  logic        illegal_id_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  input  ex_wb_pipe_t ex_wb_pipe_i,
  input  logic        wb_ready_i,
  output ctrl_byp_t   ctrl_byp_o
);

  // Per read port address matches, r0 excluded
  logic [1:0] rf_rd_ex_match;
  logic [1:0] rf_rd_wb_match;
  logic       rf_we_ex;
  logic       rf_we_wb;
  logic       load_ex;
  logic       csr_write_ex_wb;

  // Qualified writers in EX and WB
  assign rf_we_ex = id_ex_pipe_i.rf_we && id_ex_pipe_i.instr_valid;
  assign rf_we_wb = ex_wb_pipe_i.rf_we && ex_wb_pipe_i.instr_valid;

  // Only loads write rf while lsu_en is set
  assign load_ex = rf_we_ex && id_ex_pipe_i.lsu_en;

  // CSRW anywhere past ID
  assign csr_write_ex_wb = (id_ex_pipe_i.instr_valid && id_ex_pipe_i.csr_we) ||
                           (ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.csr_we);

  for (genvar i = 0; i < 2; i++) begin : gen_match
    assign rf_rd_ex_match[i] = (id_ex_pipe_i.rf_waddr == rf_raddr_id_i[i]) &&
                               |rf_raddr_id_i[i] && rf_re_id_i[i] && instr_valid_id_i;
    assign rf_rd_wb_match[i] = (ex_wb_pipe_i.rf_waddr == rf_raddr_id_i[i]) &&
                               |rf_raddr_id_i[i] && rf_re_id_i[i] && instr_valid_id_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Stalls and forwarding selects
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl_byp_o.load_stall           = 1'b0;
    ctrl_byp_o.csr_stall            = 1'b0;
    ctrl_byp_o.deassert_we          = 1'b0;
    ctrl_byp_o.operand_a_fw_mux_sel = SEL_REGFILE;
    ctrl_byp_o.operand_b_fw_mux_sel = SEL_REGFILE;

    // Illegal opcode still flows down as a no-write
    if (illegal_id_i && instr_valid_id_i) begin
      ctrl_byp_o.deassert_we = 1'b1;
    end

    // Load result not there yet, in EX or stuck in WB
    if ((load_ex && |rf_rd_ex_match) ||
        (!wb_ready_i && rf_we_wb && |rf_rd_wb_match)) begin
      ctrl_byp_o.load_stall = 1'b1;
    end

    // CSRR must see the value after any older CSRW
    if (csr_read_id_i && instr_valid_id_i && csr_write_ex_wb) begin
      ctrl_byp_o.csr_stall = 1'b1;
    end

    // WB first, EX overrides as the younger writer
    if (rf_we_wb) begin
      if (rf_rd_wb_match[0]) begin
        ctrl_byp_o.operand_a_fw_mux_sel = SEL_FW_WB;
      end
      if (rf_rd_wb_match[1]) begin
        ctrl_byp_o.operand_b_fw_mux_sel = SEL_FW_WB;
      end
    end
    if (rf_we_ex) begin
      if (rf_rd_ex_match[0]) begin
        ctrl_byp_o.operand_a_fw_mux_sel = SEL_FW_EX;
      end
      if (rf_rd_ex_match[1]) begin
        ctrl_byp_o.operand_b_fw_mux_sel = SEL_FW_EX;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/pipe_ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_ex_stage
  import pipe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  id_ex_pipe_t       id_ex_pipe_i,
  input  logic              wb_ready_i,
  output logic              ex_ready_o,
  output logic [DATA_W-1:0] ex_fw_data_o,
  output ex_wb_pipe_t       ex_wb_pipe_o
);

  logic [DATA_W-1:0] alu_result;
  ex_wb_pipe_t       ex_wb_d;
  ex_wb_pipe_t       ex_wb_q;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  // All sums wrap at 16 bits
  always_comb begin
    case (id_ex_pipe_i.op)
      ADD:           alu_result = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
      SUB:           alu_result = id_ex_pipe_i.operand_a - id_ex_pipe_i.operand_b;
      AND:           alu_result = id_ex_pipe_i.operand_a & id_ex_pipe_i.operand_b;
      OR:            alu_result = id_ex_pipe_i.operand_a | id_ex_pipe_i.operand_b;
      XOR:           alu_result = id_ex_pipe_i.operand_a ^ id_ex_pipe_i.operand_b;
      // Immediate add doubles as address adder
      ADDI, LD, ST:  alu_result = id_ex_pipe_i.operand_a + id_ex_pipe_i.imm;
      // CSR value in or out
      CSRW, CSRR:    alu_result = id_ex_pipe_i.operand_a;
      default:       alu_result = '0;
    endcase
  end

  assign ex_fw_data_o = alu_result;
  assign ex_ready_o   = wb_ready_i;

  always_comb begin
    ex_wb_d.instr_valid = id_ex_pipe_i.instr_valid;
    ex_wb_d.rf_we       = id_ex_pipe_i.rf_we;
    ex_wb_d.rf_waddr    = id_ex_pipe_i.rf_waddr;
    ex_wb_d.lsu_en      = id_ex_pipe_i.lsu_en;
    ex_wb_d.lsu_we      = id_ex_pipe_i.lsu_we;
    ex_wb_d.csr_we      = id_ex_pipe_i.csr_we;
    ex_wb_d.result      = alu_result;
    ex_wb_d.st_data     = id_ex_pipe_i.st_data;
  end

  // EX-to-WB register, frozen during a memory wait
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ex_wb_q.instr_valid <= 1'b0;
    end else if (wb_ready_i) begin
      ex_wb_q <= ex_wb_d;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

endmodule

`default_nettype wire

// ==== logic/pipe_wb_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_wb_stage
  import pipe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  ex_wb_pipe_t       ex_wb_pipe_i,
  output logic              wb_ready_o,
  output logic [DATA_W-1:0] wb_fw_data_o,
  output logic              rf_we_o,
  output rf_addr_t          rf_waddr_o,
  output logic [DATA_W-1:0] rf_wdata_o,
  output logic [DATA_W-1:0] csr_rdata_o,
  output logic              mem_req_o,
  output logic              mem_we_o,
  output logic [DATA_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  output retire_t           retire_o
);

  typedef enum logic {
    WB_ISSUE,
    WB_WAIT
  } wb_state_e;

  wb_state_e         state_q;
  wb_state_e         state_d;
  logic [DATA_W-1:0] csr_q;
  logic              mem_instr;
  logic              done;
  logic [DATA_W-1:0] wdata;

  assign mem_instr = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.lsu_en;

  // Memory ops complete on rvalid, everything else at once
  assign done = !mem_instr || ((state_q == WB_WAIT) && mem_rvalid_i);

  //////////////////////////////////////////////////////////////////////
  // Memory request FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      WB_ISSUE: begin
        if (mem_instr) begin
          state_d = WB_WAIT;
        end
      end
      WB_WAIT: begin
        if (mem_rvalid_i) begin
          state_d = WB_ISSUE;
        end
      end
      default: state_d = WB_ISSUE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= WB_ISSUE;
    end else begin
      state_q <= state_d;
    end
  end

  // Single request per memory op
  assign mem_req_o   = mem_instr && (state_q == WB_ISSUE);
  assign mem_we_o    = ex_wb_pipe_i.lsu_we;
  assign mem_addr_o  = ex_wb_pipe_i.result;
  assign mem_wdata_o = ex_wb_pipe_i.st_data;

  // Scratch CSR
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      csr_q <= '0;
    end else if (ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.csr_we) begin
      csr_q <= ex_wb_pipe_i.result;
    end
  end

  assign csr_rdata_o = csr_q;

  // Load data or ALU and CSR result
  assign wdata = (ex_wb_pipe_i.lsu_en && !ex_wb_pipe_i.lsu_we) ? mem_rdata_i
                                                               : ex_wb_pipe_i.result;

  assign wb_ready_o   = done;
  assign wb_fw_data_o = wdata;
  assign rf_we_o      = ex_wb_pipe_i.instr_valid && ex_wb_pipe_i.rf_we && done;
  assign rf_waddr_o   = ex_wb_pipe_i.rf_waddr;
  assign rf_wdata_o   = wdata;

  assign retire_o.valid = ex_wb_pipe_i.instr_valid && done;
  assign retire_o.we    = ex_wb_pipe_i.rf_we;
  assign retire_o.waddr = ex_wb_pipe_i.rf_waddr;
  assign retire_o.wdata = wdata;

  a_no_req_in_wait : assert property (@(posedge clk) disable iff (!rst_n_i)
    (state_q == WB_WAIT) |-> !mem_req_o);

  // Memory must not answer without an open request
  a_rvalid_in_wait : assert property (@(posedge clk) disable iff (!rst_n_i)
    mem_rvalid_i |-> (state_q == WB_WAIT));

endmodule

`default_nettype wire

// ==== logic/pipe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_top
  import pipe_pkg::*;
  import byp_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              instr_valid_i,
  input  instr_t            instr_i,
  output logic              instr_ready_o,
  output logic              mem_req_o,
  output logic              mem_we_o,
  output logic [DATA_W-1:0] mem_addr_o,
  output logic [DATA_W-1:0] mem_wdata_o,
  input  logic              mem_rvalid_i,
  input  logic [DATA_W-1:0] mem_rdata_i,
  output retire_t           retire_o
);

  // ID side
  logic [1:0]        rf_re;
  rf_addr_t          rf_raddr [2];
  logic [DATA_W-1:0] rf_rdata [2];
  logic              csr_read;
  logic              illegal;
  ctrl_byp_t         ctrl_byp;

  // Forwarding sources and readiness
  logic [DATA_W-1:0] ex_fw_data;
  logic [DATA_W-1:0] wb_fw_data;
  logic              ex_ready;
  logic              wb_ready;
  id_ex_pipe_t       id_ex_pipe;
  ex_wb_pipe_t       ex_wb_pipe;

  // Write-back into the register file
  logic              rf_we;
  rf_addr_t          rf_waddr;
  logic [DATA_W-1:0] rf_wdata;
  logic [DATA_W-1:0] csr_rdata;

  pipe_id_stage u_id (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .rf_re_o       (rf_re),
    .rf_raddr_o    (rf_raddr),
    .rf_rdata_i    (rf_rdata),
    .csr_read_o    (csr_read),
    .illegal_o     (illegal),
    .csr_rdata_i   (csr_rdata),
    .ctrl_byp_i    (ctrl_byp),
    .ex_fw_data_i  (ex_fw_data),
    .wb_fw_data_i  (wb_fw_data),
    .ex_ready_i    (ex_ready),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  pipe_regfile u_rf (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .raddr_i (rf_raddr),
    .rdata_o (rf_rdata),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata)
  );

  pipe_bypass_ctrl u_byp (
    .rf_re_id_i       (rf_re),
    .rf_raddr_id_i    (rf_raddr),
    .csr_read_id_i    (csr_read),
    .instr_valid_id_i (instr_valid_i),
    .illegal_id_i     (illegal),
    .id_ex_pipe_i     (id_ex_pipe),
    .ex_wb_pipe_i     (ex_wb_pipe),
    .wb_ready_i       (wb_ready),
    .ctrl_byp_o       (ctrl_byp)
  );

  pipe_ex_stage u_ex (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .id_ex_pipe_i (id_ex_pipe),
    .wb_ready_i   (wb_ready),
    .ex_ready_o   (ex_ready),
    .ex_fw_data_o (ex_fw_data),
    .ex_wb_pipe_o (ex_wb_pipe)
  );

  pipe_wb_stage u_wb (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .ex_wb_pipe_i (ex_wb_pipe),
    .wb_ready_o   (wb_ready),
    .wb_fw_data_o (wb_fw_data),
    .rf_we_o      (rf_we),
    .rf_waddr_o   (rf_waddr),
    .rf_wdata_o   (rf_wdata),
    .csr_rdata_o  (csr_rdata),
    .mem_req_o    (mem_req_o),
    .mem_we_o     (mem_we_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .retire_o     (retire_o)
  );

endmodule

`default_nettype wire

// ==== verif/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker
  import pipe_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              instr_valid_i,
  input  logic              instr_ready_i,
  input  instr_t            instr_i,
  input  logic              mem_req_i,
  input  logic              mem_we_i,
  input  logic [DATA_W-1:0] mem_addr_i,
  input  logic [DATA_W-1:0] mem_wdata_i,
  input  retire_t           retire_i,
  output int unsigned       outstanding_o,
  output int unsigned       retired_o,
  output int unsigned       errors_o
);

  // Accepted instruction waiting for its retire
  typedef struct packed {
    instr_t      ins;
    // Set when the retire must land exactly two cycles later
    logic        timed;
    logic [31:0] due_cyc;
  } acc_entry_t;

  // Request seen on the memory port
  typedef struct packed {
    logic              we;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  logic [DATA_W-1:0] regs [NUM_REGS];
  logic [DATA_W-1:0] csr;
  logic [DATA_W-1:0] mem [256];
  acc_entry_t        acc_q [$];
  mem_req_t          mreq_q [$];
  logic [31:0]       cyc;
  int unsigned       errors;
  int unsigned       retired;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Start image of the memory, every address bit matters
  function automatic logic [DATA_W-1:0] init_word(input logic [7:0] idx);
    return {idx ^ 8'h3c, idx * 8'd7 + 8'h11};
  endfunction

  task automatic report_err(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic reset_model();
    for (int i = 0; i < NUM_REGS; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mem[i] = init_word(i[7:0]);
    end
    csr = '0;
    cyc = '0;
    acc_q.delete();
    mreq_q.delete();
  endtask

  // Oldest outstanding request must be this access
  task automatic check_mem_req(input logic we, input logic [DATA_W-1:0] addr,
                               input logic [DATA_W-1:0] wdata);
    mem_req_t m;
    if (mreq_q.size() == 0) begin
      report_err("memory instruction retired without a request on the port");
      return;
    end
    m = mreq_q.pop_front();
    if (m.we != we || m.addr != addr) begin
      report_err($sformatf("mem request we=%0b addr=%h, expected we=%0b addr=%h",
                           m.we, m.addr, we, addr));
    end else if (we && m.wdata != wdata) begin
      report_err($sformatf("store data %h at %h, expected %h", m.wdata, addr, wdata));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequential reference model, run at each retire
  //////////////////////////////////////////////////////////////////////

  task automatic check_retire();
    acc_entry_t        e;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] addr;
    logic [DATA_W-1:0] res;
    logic              exp_we;
    if (acc_q.size() == 0) begin
      report_err("retire seen with no accepted instruction outstanding");
      return;
    end
    e      = acc_q.pop_front();
    a      = regs[e.ins.rs1];
    b      = regs[e.ins.lo.rr.rs2];
    imm    = {{(DATA_W-6){e.ins.lo.imm[5]}}, e.ins.lo.imm};
    addr   = a + imm;
    res    = '0;
    exp_we = 1'b0;
    case (e.ins.op)
      ADD:  begin res = a + b; exp_we = 1'b1; end
      SUB:  begin res = a - b; exp_we = 1'b1; end
      AND:  begin res = a & b; exp_we = 1'b1; end
      OR:   begin res = a | b; exp_we = 1'b1; end
      XOR:  begin res = a ^ b; exp_we = 1'b1; end
      ADDI: begin res = addr;  exp_we = 1'b1; end
      LD: begin
        check_mem_req(1'b0, addr, '0);
        res    = mem[addr[7:0]];
        exp_we = 1'b1;
      end
      // Store data register sits in the rd field
      ST: begin
        check_mem_req(1'b1, addr, regs[e.ins.rd]);
        mem[addr[7:0]] = regs[e.ins.rd];
      end
      CSRW: csr = a;
      CSRR: begin res = csr; exp_we = 1'b1; end
      // NOP and illegal codes change nothing
      default: exp_we = 1'b0;
    endcase
    // Only loads and stores may put a request on the port
    if (e.ins.op != LD && e.ins.op != ST && mreq_q.size() != 0) begin
      report_err($sformatf("op %0d issued a memory request", e.ins.op));
      mreq_q.delete();
    end
    // r0 is never written
    if (e.ins.rd == '0) begin
      exp_we = 1'b0;
    end
    if (retire_i.we != exp_we) begin
      report_err($sformatf("op %0d retired with we=%0b, expected %0b",
                           e.ins.op, retire_i.we, exp_we));
    end else if (exp_we && (retire_i.waddr != e.ins.rd || retire_i.wdata != res)) begin
      report_err($sformatf("op %0d wrote r%0d=%h, expected r%0d=%h", e.ins.op,
                           retire_i.waddr, retire_i.wdata, e.ins.rd, res));
    end
    if (exp_we) begin
      regs[e.ins.rd] = res;
    end
    if (e.timed && cyc != e.due_cyc) begin
      report_err($sformatf("retire at cycle %0d, expected cycle %0d", cyc, e.due_cyc));
    end
    retired++;
  endtask

  // Empty pipe and no memory access gives a fixed two cycle latency
  task automatic log_accept();
    acc_entry_t e;
    e.ins     = instr_i;
    e.timed   = (acc_q.size() == 0) && (instr_i.op != LD) && (instr_i.op != ST);
    e.due_cyc = cyc + 32'd2;
    acc_q.push_back(e);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Port sampling
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n_i) begin
      reset_model();
    end else begin
      cyc = cyc + 32'd1;
      if (mem_req_i) begin
        mreq_q.push_back('{we: mem_we_i, addr: mem_addr_i, wdata: mem_wdata_i});
      end
      // Retire first so a same-edge acceptance sees the drained pipe
      if (retire_i.valid) begin
        check_retire();
      end
      if (instr_valid_i && instr_ready_i) begin
        log_accept();
      end
    end
    outstanding_o <= acc_q.size();
    retired_o     <= retired;
    errors_o      <= errors;
  end

endmodule

`default_nettype wire

// ==== verif/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top
  import pipe_pkg::*;
();

  localparam int unsigned NUM_INSTR      = 2000;
  localparam int unsigned RESET_CYCLES   = 8;
  localparam int unsigned ACCEPT_TIMEOUT = 64;
  localparam int unsigned DRAIN_TIMEOUT  = 200;
  localparam logic [31:0] SEED           = 32'h3cc2_499e;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              instr_valid;
  instr_t            instr;
  logic              instr_ready;
  logic              mem_req;
  logic              mem_we;
  logic [DATA_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic              mem_rvalid = 1'b0;
  logic [DATA_W-1:0] mem_rdata  = '0;
  retire_t           retire;

  // Checker outputs
  int unsigned outstanding;
  int unsigned retired;
  int unsigned err_cnt;

  // Memory model state
  logic [DATA_W-1:0] tb_mem [256];
  logic              mem_busy  = 1'b0;
  logic [7:0]        mem_idx   = '0;
  int unsigned       mem_delay = 0;

  // Generator state
  rf_addr_t recent [3];
  logic     csr_follow;
  logic     hung;

  always #50 clk = ~clk;

  pipe_top u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .instr_ready_o (instr_ready),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .retire_o      (retire)
  );

  tb_checker u_chk (
    .clk           (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_ready_i (instr_ready),
    .instr_i       (instr),
    .mem_req_i     (mem_req),
    .mem_we_i      (mem_we),
    .mem_addr_i    (mem_addr),
    .mem_wdata_i   (mem_wdata),
    .retire_i      (retire),
    .outstanding_o (outstanding),
    .retired_o     (retired),
    .errors_o      (err_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // Memory model, one request at a time, 1 to 4 cycles to answer
  //////////////////////////////////////////////////////////////////////

  function automatic logic [DATA_W-1:0] init_word(input logic [7:0] idx);
    return {idx ^ 8'h3c, idx * 8'd7 + 8'h11};
  endfunction

  always @(negedge clk) begin
    mem_rvalid = 1'b0;
    if (!rst_n) begin
      mem_busy = 1'b0;
    end else if (mem_busy) begin
      mem_delay = mem_delay - 1;
      if (mem_delay == 0) begin
        mem_rvalid = 1'b1;
        mem_rdata  = tb_mem[mem_idx];
        mem_busy   = 1'b0;
      end
    end else if (mem_req) begin
      mem_busy  = 1'b1;
      mem_idx   = mem_addr[7:0];
      mem_delay = $urandom_range(1, 4);
      // Stores land at request time
      if (mem_we) begin
        tb_mem[mem_idx] = mem_wdata;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random instruction stream
  //////////////////////////////////////////////////////////////////////

  // Mostly reuse recent destinations to build hazards
  function automatic rf_addr_t pick_src();
    if ($urandom_range(0, 99) < 65) begin
      return recent[$urandom_range(0, 2)];
    end
    return rf_addr_t'($urandom_range(0, 7));
  endfunction

  task automatic pick_instr(output instr_t ins);
    int unsigned roll;
    logic [3:0]  opc;
    roll = $urandom_range(0, 99);
    if (csr_follow) begin
      opc        = CSRR;
      csr_follow = 1'b0;
    end else if (roll < 34) begin
      opc = 4'($urandom_range(1, 5));
    end else if (roll < 46) begin
      opc = ADDI;
    end else if (roll < 62) begin
      opc = LD;
    end else if (roll < 72) begin
      opc = ST;
    end else if (roll < 80) begin
      opc        = CSRW;
      csr_follow = ($urandom_range(0, 99) < 60);
    end else if (roll < 86) begin
      opc = CSRR;
    end else if (roll < 92) begin
      opc = NOP;
    end else begin
      // Codes past CSRR are illegal
      opc = 4'($urandom_range(11, 15));
    end
    ins.op  = opc;
    ins.rs1 = pick_src();
    // rd names the store data for ST, r0 now and then elsewhere
    if (opc == ST) begin
      ins.rd = pick_src();
    end else if ($urandom_range(0, 9) == 0) begin
      ins.rd = '0;
    end else begin
      ins.rd = rf_addr_t'($urandom_range(1, 7));
    end
    if (opc == ADDI || opc == LD || opc == ST) begin
      ins.lo.imm = 6'($urandom);
    end else begin
      ins.lo.rr.rs2   = pick_src();
      ins.lo.rr.spare = 3'($urandom);
    end
    if ((opc >= ADD && opc <= LD) || opc == CSRR) begin
      recent[2] = recent[1];
      recent[1] = recent[0];
      recent[0] = ins.rd;
    end
  endtask

  // Present one instruction until accepted, valid randomly dropped
  task automatic send_instr(input instr_t ins);
    int unsigned waited;
    logic        taken;
    waited = 0;
    taken  = 1'b0;
    while (!taken && !hung) begin
      @(negedge clk);
      instr_valid = ($urandom_range(0, 99) >= 15);
      instr       = ins;
      @(posedge clk);
      if (instr_valid && instr_ready) begin
        taken = 1'b1;
      end else begin
        waited++;
        if (waited > ACCEPT_TIMEOUT) begin
          $display("Timeout: instruction not accepted within %0d cycles", ACCEPT_TIMEOUT);
          hung = 1'b1;
        end
      end
    end
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (outstanding != 0 && !hung) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_TIMEOUT && outstanding != 0) begin
        $display("Timeout: %0d accepted instructions never retired", outstanding);
        hung = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    instr_t next_ins;
    void'($urandom(SEED));
    hung        = 1'b0;
    csr_follow  = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    for (int i = 0; i < 3; i++) begin
      recent[i] = rf_addr_t'(i + 1);
    end
    for (int i = 0; i < 256; i++) begin
      tb_mem[i] = init_word(i[7:0]);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int n = 0; n < NUM_INSTR && !hung; n++) begin
      pick_instr(next_ins);
      send_instr(next_ins);
    end
    @(negedge clk);
    instr_valid = 1'b0;
    wait_drain();
    @(negedge clk);

    if (!hung && retired != NUM_INSTR) begin
      $display("Retire count %0d does not match %0d accepted instructions",
               retired, NUM_INSTR);
    end
    $display("Retired %0d of %0d instructions, %0d errors, %0d timeouts",
             retired, NUM_INSTR, err_cnt, hung);
    if (!hung && err_cnt == 0 && retired == NUM_INSTR) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/pipe_pkg.sv
logic/byp_pkg.sv
logic/pipe_regfile.sv
logic/pipe_id_stage.sv
logic/pipe_bypass_ctrl.sv
logic/pipe_ex_stage.sv
logic/pipe_wb_stage.sv
logic/pipe_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// ==== Makefile ====
SIM      := verilator
TOP      := tb_top
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
